//--- include/rgb565_colors.svh
`ifndef RGB565_COLORS_SVH
`define RGB565_COLORS_SVH

// RGB565 packing: red [15:11], green [10:5], blue [4:0].

`define COLOR_RED        16'hF800 // Full red.
`define COLOR_WHITE      16'hFFFF // All channels max.
`define COLOR_BLACK      16'h0000 // All channels off.

// Dark slate page background.
`define COLOR_BACKGROUND 16'h18E3

`endif

//--- logic/page_render_pkg.sv
`default_nettype none

package page_render_pkg;

`include "rgb565_colors.svh"

    ////////////////////
    // Framebuffer geometry.
    localparam int SCREEN_W     = 480;
    localparam int SCREEN_H     = 800;
    localparam int FB_PIXELS    = SCREEN_W * SCREEN_H;
    localparam int FB_AW        = $clog2(FB_PIXELS); // 19 bits of pixel address.
    localparam int PIX_PER_BEAT = 4;                 // One SDRAM burst word.
    localparam int WB_SEL_W     = PIX_PER_BEAT * 2;  // Byte lanes per beat.

    ////////////////////
    // Glyph ROM layout, row-major, LSB is the leftmost column.
    localparam int GLYPH_W     = 16;
    localparam int GLYPH_H     = 16;
    localparam int GLYPH_BYTES = GLYPH_W * GLYPH_H / 8;
    localparam int GLYPH_COUNT = 4;
    localparam int ROM_BYTES   = GLYPH_BYTES * GLYPH_COUNT;
    localparam int ROM_AW      = $clog2(ROM_BYTES); // 7 bits.

    typedef logic [15:0] rgb565_t;
    typedef logic [FB_AW-1:0] fb_addr_t; // y * SCREEN_W + x.
    typedef logic [9:0] coord_t;

    // Four pixels, px0 sits at the lowest address.
    typedef struct packed {
        rgb565_t px3;
        rgb565_t px2;
        rgb565_t px1;
        rgb565_t px0;
    } fb_beat_t;

    typedef struct packed {
        fb_addr_t adr;
        fb_beat_t dat;
    } fb_write_t;

    typedef enum logic {
        JOB_FILL,
        JOB_GLYPH
    } job_kind_t;

    typedef struct packed {
        job_kind_t                        kind;
        coord_t                           x;     // Multiple of 4.
        coord_t                           y;
        coord_t                           w;     // Multiple of 4.
        coord_t                           h;
        logic [$clog2(GLYPH_COUNT)-1:0]   glyph;
        rgb565_t                          fg;
        rgb565_t                          bg;
    } job_t;

    ////////////////////
    // Fixed status page, later jobs overwrite earlier ones.
    localparam int JOB_COUNT = 6;

    typedef logic [$clog2(JOB_COUNT)-1:0] job_idx_t;

    localparam job_idx_t JOB_LAST = job_idx_t'(JOB_COUNT - 1);

    localparam job_t JOB_TABLE [JOB_COUNT] = '{
        '{JOB_FILL,  10'd0,   10'd0,   10'd480, 10'd800, 2'd0,
          `COLOR_BACKGROUND, `COLOR_BACKGROUND},                        // Clear.
        '{JOB_GLYPH, 10'd436, 10'd628, 10'd16,  10'd16,  2'd0, `COLOR_WHITE, `COLOR_BLACK},
        '{JOB_GLYPH, 10'd436, 10'd644, 10'd16,  10'd16,  2'd1, `COLOR_WHITE, `COLOR_BLACK},
        '{JOB_GLYPH, 10'd204, 10'd628, 10'd16,  10'd16,  2'd2, `COLOR_WHITE, `COLOR_BLACK},
        '{JOB_GLYPH, 10'd204, 10'd644, 10'd16,  10'd16,  2'd3, `COLOR_WHITE, `COLOR_BLACK},
        '{JOB_FILL,  10'd0,   10'd0,   10'd480, 10'd8,   2'd0,
          `COLOR_RED, `COLOR_RED}                                       // Title bar.
    };

endpackage

`default_nettype wire

//--- logic/glyph_rom.sv
`timescale 1ns/100ps
`default_nettype none

// Registered read, so data lags the address by one clock.
module glyph_rom (
    input  wire logic                                clk,
    input  wire logic [page_render_pkg::ROM_AW-1:0]  rom_addr,
    output logic [7:0]                               rom_data
);

    logic [7:0] mem [page_render_pkg::ROM_BYTES]; // 4 glyphs of 32 bytes.

    initial
    begin
        $readmemh("glyphs.hex", mem); // Two bytes per glyph row.
    end

    always_ff @(posedge clk)
    begin
        rom_data <= mem[rom_addr];
    end

endmodule

`default_nettype wire

//--- logic/page_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module page_sequencer (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             en,
    input  wire logic             start,
    output logic                  busy,
    output logic                  done,
    output page_render_pkg::job_t job,
    output logic                  job_valid,
    input  wire logic             job_ready,
    input  wire logic             job_last_done
);

    typedef enum logic [1:0] {
        S_IDLE,  // Waiting for start.
        S_OFFER, // Job presented to the blitter.
        S_WAIT   // Blitter drawing, wait for its last write.
    } state_t;

    state_t                      state;
    page_render_pkg::job_idx_t   idx;

    assign job       = page_render_pkg::JOB_TABLE[idx];
    assign job_valid = (state == S_OFFER);
    assign busy      = (state != S_IDLE); // Drops on the same edge that raises done.

    ////////////////////
    // Job list walk.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0; // Pulse even if en falls right after.
            if (en)
            begin
                case (state)
                    S_IDLE:
                    begin
                        if (start) // A start while busy never reaches here.
                        begin
                            idx   <= '0;
                            state <= S_OFFER;
                        end
                    end
                    S_OFFER:
                    begin
                        if (job_ready)
                        begin
                            state <= S_WAIT; // Handed over.
                        end
                    end
                    S_WAIT:
                    begin
                        if (job_last_done)
                        begin
                            if (idx == page_render_pkg::JOB_LAST)
                            begin
                                done  <= 1'b1;
                                state <= S_IDLE;
                            end
                            else
                            begin
                                idx   <= idx + 1'b1; // Next job in table order.
                                state <= S_OFFER;
                            end
                        end
                    end
                    default:
                    begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/tile_blitter.sv
`timescale 1ns/100ps
`default_nettype none

module tile_blitter (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                en,
    input  wire page_render_pkg::job_t               job,
    input  wire logic                                job_valid,
    output logic                                     job_ready,
    output logic                                     job_last_done,
    output logic [page_render_pkg::ROM_AW-1:0]       rom_addr,
    input  wire logic [7:0]                          rom_data,
    output page_render_pkg::fb_write_t               req,
    output logic                                     req_valid,
    input  wire logic                                req_ready
);

    typedef enum logic [1:0] {
        B_IDLE, // Ready for a job.
        B_LOAD, // First glyph byte arriving from ROM.
        B_BEAT  // Issuing beats.
    } state_t;

    state_t                                 state;
    page_render_pkg::job_t                  cur;        // Latched job.
    page_render_pkg::fb_addr_t              addr;       // Running pixel address.
    page_render_pkg::fb_addr_t              start_addr;
    page_render_pkg::fb_addr_t              row_skip;
    page_render_pkg::coord_t                col;        // Offset in the row, steps of 4.
    page_render_pkg::coord_t                row;
    logic [page_render_pkg::ROM_AW-1:0]     ptr;        // Next byte to take from ROM.
    logic [page_render_pkg::ROM_AW-1:0]     glyph_base;
    logic [7:0]                             byte_q;     // Byte being expanded.
    logic [3:0]                             nib;
    logic                                   job_fire;
    logic                                   req_fire;
    logic                                   col_last;
    logic                                   row_last;
    logic                                   is_glyph;
    page_render_pkg::fb_beat_t              beat;

    assign job_ready = (state == B_IDLE) && en; // Frozen while en is low.
    assign req_valid = (state == B_BEAT) && en;
    assign job_fire  = job_valid && job_ready;
    assign req_fire  = req_valid && req_ready;

    assign col_last      = (col == cur.w - page_render_pkg::coord_t'(4));
    assign row_last      = (row == cur.h - page_render_pkg::coord_t'(1));
    assign job_last_done = req_fire && col_last && row_last;
    assign is_glyph      = (cur.kind == page_render_pkg::JOB_GLYPH);

    // y * 480 as y * 512 - y * 32.
    assign start_addr = (page_render_pkg::fb_addr_t'(job.y) << 9)
                      - (page_render_pkg::fb_addr_t'(job.y) << 5)
                      + page_render_pkg::fb_addr_t'(job.x);
    assign row_skip   = page_render_pkg::fb_addr_t'(page_render_pkg::SCREEN_W)
                      - page_render_pkg::fb_addr_t'(cur.w);
    assign glyph_base = {job.glyph, 5'd0}; // 32 bytes per glyph.

    // First byte is addressed straight from the incoming job.
    assign rom_addr = (state == B_IDLE) ? glyph_base : ptr;

    ////////////////////
    // Pixel expansion.
    assign nib = col[2] ? byte_q[7:4] : byte_q[3:0]; // Low nibble on even beats.

    always_comb
    begin
        if (is_glyph)
        begin
            beat.px0 = nib[0] ? cur.fg : cur.bg; // Leftmost pixel.
            beat.px1 = nib[1] ? cur.fg : cur.bg;
            beat.px2 = nib[2] ? cur.fg : cur.bg;
            beat.px3 = nib[3] ? cur.fg : cur.bg;
        end
        else
        begin
            beat = '{default: cur.fg}; // Solid fill.
        end
    end

    assign req.adr = addr;
    assign req.dat = beat;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= B_IDLE;
        end
        else
        begin
            case (state)
                B_IDLE:
                begin
                    if (job_fire)
                    begin
                        state <= (job.kind == page_render_pkg::JOB_GLYPH) ? B_LOAD : B_BEAT;
                    end
                end
                B_LOAD:
                begin
                    if (en)
                    begin
                        state <= B_BEAT;
                    end
                end
                B_BEAT:
                begin
                    if (job_last_done)
                    begin
                        state <= B_IDLE;
                    end
                end
                default:
                begin
                    state <= B_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Rectangle walk and ROM prefetch.
    always_ff @(posedge clk)
    begin
        if (job_fire)
        begin
            cur  <= job;
            addr <= start_addr;
            col  <= '0;
            row  <= '0;
            ptr  <= glyph_base;
        end
        if ((state == B_LOAD) && en)
        begin
            byte_q <= rom_data;    // ROM held on ptr, so data is still valid.
            ptr    <= ptr + 1'b1; // Start fetching the following byte.
        end
        if (req_fire)
        begin
            if (col_last)
            begin
                col  <= '0;
                row  <= row + 1'b1;
                addr <= addr + page_render_pkg::fb_addr_t'(4) + row_skip; // Next row start.
            end
            else
            begin
                col  <= col + page_render_pkg::coord_t'(4);
                addr <= addr + page_render_pkg::fb_addr_t'(4);
            end
            if (is_glyph && col[2])
            begin
                byte_q <= rom_data; // Prefetched during the low nibble beat.
                ptr    <= ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/wb_write_master.sv
`timescale 1ns/100ps
`default_nettype none

module wb_write_master (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire page_render_pkg::fb_write_t           req,
    input  wire logic                                 req_valid,
    output logic                                      req_ready,
    output logic                                      wb_cyc,
    output logic                                      wb_stb,
    output logic                                      wb_we,
    output page_render_pkg::fb_addr_t                 wb_adr,
    output page_render_pkg::fb_beat_t                 wb_dat,
    output logic [page_render_pkg::WB_SEL_W-1:0]      wb_sel,
    input  wire logic                                 wb_ack
);

    logic                          bus_valid; // Cycle on the bus.
    logic                          buf_valid; // Skid entry waiting.
    logic                          bus_free;
    logic                          req_fire;
    page_render_pkg::fb_write_t    bus_q;
    page_render_pkg::fb_write_t    buf_q;

    assign req_ready = !buf_valid;
    assign req_fire  = req_valid && req_ready;
    assign bus_free  = !bus_valid || wb_ack; // Ack frees the bus register this edge.

    assign wb_cyc = bus_valid;
    assign wb_stb = bus_valid;
    assign wb_we  = bus_valid; // Write only.
    assign wb_adr = bus_q.adr;
    assign wb_dat = bus_q.dat;
    assign wb_sel = '1;        // Full four-pixel beat.

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bus_valid <= 1'b0;
            buf_valid <= 1'b0;
        end
        else
        begin
            if (bus_free)
            begin
                bus_valid <= buf_valid || req_fire; // Back to back if one waits.
                buf_valid <= 1'b0;
            end
            else if (req_fire)
            begin
                buf_valid <= 1'b1; // Bus busy, park it.
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus_free)
        begin
            bus_q <= buf_valid ? buf_q : req; // Older request first.
        end
        if (req_fire && !bus_free)
        begin
            buf_q <= req;
        end
    end

endmodule

`default_nettype wire

//--- logic/page_render_top.sv
`timescale 1ns/100ps
`default_nettype none

module page_render_top (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 en,
    input  wire logic                                 start,
    output logic                                      busy,
    output logic                                      done,
    output logic                                      wb_cyc,
    output logic                                      wb_stb,
    output logic                                      wb_we,
    output page_render_pkg::fb_addr_t                 wb_adr,
    output page_render_pkg::fb_beat_t                 wb_dat,
    output logic [page_render_pkg::WB_SEL_W-1:0]      wb_sel,
    input  wire logic                                 wb_ack
);

    page_render_pkg::job_t               job;
    logic                                job_valid;
    logic                                job_ready;
    logic                                job_last_done;
    logic [page_render_pkg::ROM_AW-1:0]  rom_addr;
    logic [7:0]                          rom_data;
    page_render_pkg::fb_write_t          req;
    logic                                req_valid;
    logic                                req_ready;

    ////////////////////
    // Job control.
    page_sequencer i_page_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .job           (job),
        .job_valid     (job_valid),
        .job_ready     (job_ready),
        .job_last_done (job_last_done)
    );

    tile_blitter i_tile_blitter (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .job           (job),
        .job_valid     (job_valid),
        .job_ready     (job_ready),
        .job_last_done (job_last_done),
        .rom_addr      (rom_addr),
        .rom_data      (rom_data),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready)
    );

    glyph_rom i_glyph_rom (
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    // Not gated by en, so a started bus cycle always finishes.
    wb_write_master i_wb_write_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat    (wb_dat),
        .wb_sel    (wb_sel),
        .wb_ack    (wb_ack)
    );

endmodule

`default_nettype wire

//--- verif/fb_memory_model.sv
`timescale 1ns/100ps
`default_nettype none

// Wishbone classic slave holding framebuffer pixels.
module fb_memory_model (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire logic                                  wb_cyc,
    input  wire logic                                  wb_stb,
    input  wire logic                                  wb_we,
    input  wire page_render_pkg::fb_addr_t             wb_adr,
    input  wire page_render_pkg::fb_beat_t             wb_dat,
    input  wire logic [page_render_pkg::WB_SEL_W-1:0]  wb_sel,
    output logic                                       wb_ack
);

    localparam logic [15:0] MARKER = 16'hDEAD; // Read back for unwritten pixels.

    logic [15:0] mem [int]; // Sparse pixel store.
    logic        waiting;   // Strobe seen, delay running.
    int          wait_left;
    int          delay;
    int          write_count;

    function automatic logic [15:0] read_pixel(input int a);
        return mem.exists(a) ? mem[a] : MARKER;
    endfunction

    task automatic clear_mem();
        mem.delete();
        write_count = 0;
    endtask

    task automatic store_beat();
        page_render_pkg::rgb565_t px [4];
        int                       k;
        px[0] = wb_dat.px0; // Lowest address.
        px[1] = wb_dat.px1;
        px[2] = wb_dat.px2;
        px[3] = wb_dat.px3;
        for (k = 0; k < page_render_pkg::PIX_PER_BEAT; k++)
        begin
            if (&wb_sel[2*k +: 2])
            begin
                mem[int'(wb_adr) + k] = px[k];
            end
        end
        write_count++;
    endtask

    ////////////////////
    // Ack after 0 to 3 extra cycles.
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_ack    <= 1'b0;
            waiting   <= 1'b0;
            wait_left <= 0;
        end
        else
        begin
            wb_ack <= 1'b0; // One-cycle ack.
            if (wb_cyc && wb_stb && !wb_ack)
            begin
                if (!waiting)
                begin
                    delay = $urandom_range(3, 0);
                    if (delay == 0)
                    begin
                        if (wb_we) store_beat();
                        wb_ack <= 1'b1;
                    end
                    else
                    begin
                        waiting   <= 1'b1;
                        wait_left <= delay - 1;
                    end
                end
                else if (wait_left == 0)
                begin
                    if (wb_we) store_beat();
                    wb_ack  <= 1'b1;
                    waiting <= 1'b0;
                end
                else
                begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/page_render_assert.sv
`timescale 1ns/100ps
`default_nettype none

// Bus and handshake checks around the write master.
module page_render_assert (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       done,
    input  wire logic                       req_valid,
    input  wire logic                       wb_cyc,
    input  wire logic                       wb_stb,
    input  wire logic                       wb_ack,
    input  wire page_render_pkg::fb_addr_t  wb_adr,
    input  wire page_render_pkg::fb_beat_t  wb_dat
);

    // No bus cycle while reset is held.
    reset_idle: assert property (@(posedge clk) !rst_n |-> !wb_cyc)
    else
    begin
        $error("wb_cyc high while rst_n is low");
        page_render_tb.assert_errors++;
    end

    stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
    else
    begin
        $error("wb_stb high outside wb_cyc");
        page_render_tb.assert_errors++;
    end

    // Address and data frozen until the slave acks.
    held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat))
    else
    begin
        $error("wb_adr or wb_dat changed before wb_ack");
        page_render_tb.assert_errors++;
    end

    done_drained: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> !req_valid)
    else
    begin
        $error("done raised with a write request still pending");
        page_render_tb.assert_errors++;
    end

endmodule

`default_nettype wire

//--- verif/page_render_tb.sv
`timescale 1ns/100ps
`default_nettype none

module page_render_tb;

    localparam int  RUNS        = 2;
    localparam int  RUN_WRITES  = 96000 + 960 + 4 * 64; // Clear, title bar, four glyphs.
    localparam real WATCHDOG_NS = RUNS * RUN_WRITES * 10 * 8.0;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 en;
    logic                                 start;
    logic                                 busy;
    logic                                 done;
    logic                                 wb_cyc;
    logic                                 wb_stb;
    logic                                 wb_we;
    page_render_pkg::fb_addr_t            wb_adr;
    page_render_pkg::fb_beat_t            wb_dat;
    logic [page_render_pkg::WB_SEL_W-1:0] wb_sel;
    logic                                 wb_ack;
    int                                   assert_errors; // Bumped by the bound checker.
    logic [7:0]                           glyph_bytes [page_render_pkg::ROM_BYTES];

    always #4 clk = ~clk; // 8 ns period.

    page_render_top i_page_render_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .start  (start),
        .busy   (busy),
        .done   (done),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_adr (wb_adr),
        .wb_dat (wb_dat),
        .wb_sel (wb_sel),
        .wb_ack (wb_ack)
    );

    fb_memory_model i_fb_memory_model (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_adr (wb_adr),
        .wb_dat (wb_dat),
        .wb_sel (wb_sel),
        .wb_ack (wb_ack)
    );

    bind page_render_top page_render_assert i_page_render_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .req_valid (req_valid),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_ack    (wb_ack),
        .wb_adr    (wb_adr),
        .wb_dat    (wb_dat)
    );

    ////////////////////
    // Reference image.
    function automatic page_render_pkg::rgb565_t expected_pixel(input int x, input int y);
        page_render_pkg::job_t j;
        int                    n;
        int                    col;
        int                    row;
        logic [7:0]            b;
        for (n = page_render_pkg::JOB_COUNT - 1; n >= 0; n--) // Last covering job wins.
        begin
            j = page_render_pkg::JOB_TABLE[n];
            if (x >= int'(j.x) && x < int'(j.x) + int'(j.w)
                && y >= int'(j.y) && y < int'(j.y) + int'(j.h))
            begin
                if (j.kind == page_render_pkg::JOB_FILL)
                begin
                    return j.fg;
                end
                col = x - int'(j.x);
                row = y - int'(j.y);
                b   = glyph_bytes[int'(j.glyph) * page_render_pkg::GLYPH_BYTES
                                  + row * 2 + col / 8];
                return b[col % 8] ? j.fg : j.bg;
            end
        end
        return '0; // Unreachable as the clear covers every pixel.
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1; // Drive and sample just past the edge.
    endtask

    task automatic pulse_start();
        start = 1'b1;
        tick();
        start = 1'b0;
    endtask

    // Wait for done while optionally toggling en.
    task automatic wait_done(input string run_name, input bit stall);
        do
        begin
            tick();
            if (stall && !done)
            begin
                en = ($urandom_range(4, 0) != 0); // Low about one cycle in five.
            end
        end
        while (!done);
        en = 1'b1;
        check({run_name, " busy with done"}, 0, busy);
        tick();
        check({run_name, " done width"}, 0, done);
        while (wb_cyc)
        begin
            tick(); // Last beats still on the bus.
        end
    endtask

    task automatic compare_image(input string run_name);
        int a;
        int x;
        int y;
        for (a = 0; a < page_render_pkg::FB_PIXELS; a++)
        begin
            x = a % page_render_pkg::SCREEN_W;
            y = a / page_render_pkg::SCREEN_W;
            check($sformatf("%s pixel x=%0d y=%0d", run_name, x, y),
                  expected_pixel(x, y), i_fb_memory_model.read_pixel(a));
        end
    endtask

    ////////////////////
    // Every acked write.
    always @(negedge clk)
    begin
        if (rst_n && wb_stb && wb_ack)
        begin
            check("wb_adr alignment", 0, wb_adr % page_render_pkg::PIX_PER_BEAT);
            check("wb_adr range", 1, wb_adr < page_render_pkg::FB_PIXELS);
            check("wb_sel", 8'hFF, wb_sel);
            check("wb_we", 1, wb_we);
        end
    end

    // First failed bus assertion ends the run.
    initial
    begin
        wait (assert_errors != 0);
        $display("A bound bus assertion failed during the run");
        $display(">>> FAIL");
        $fatal(1, "Stopped at first assertion failure");
    end

    initial
    begin
        void'($urandom(28));
        clk           = 1'b0;
        rst_n         = 1'b0;
        en            = 1'b1;
        start         = 1'b0;
        assert_errors = 0;
        $readmemh("glyphs.hex", glyph_bytes);
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        check("reset wb_cyc", 0, wb_cyc);
        check("reset wb_stb", 0, wb_stb);
        check("reset wb_we", 0, wb_we);
        check("reset busy", 0, busy);
        check("reset done", 0, done);

        // Run 1 with a stray start in the middle.
        tick();
        pulse_start();
        check("busy after start", 1, busy);
        repeat (20) tick();
        pulse_start();
        check("busy after ignored start", 1, busy);
        wait_done("run 1", 1'b0);
        check("run 1 write count", RUN_WRITES, i_fb_memory_model.write_count);
        compare_image("run 1");

        // Run 2 over a marked memory with en stalling.
        i_fb_memory_model.clear_mem();
        pulse_start();
        wait_done("run 2", 1'b1);
        check("run 2 write count", RUN_WRITES, i_fb_memory_model.write_count);
        compare_image("run 2");

        if (assert_errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display("%0d assertion failures during the run", assert_errors);
            $display(">>> FAIL");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the renderer did not finish both runs in time");
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: page_render

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/page_render_pkg.sv
      - logic/glyph_rom.sv
      - logic/page_sequencer.sv
      - logic/tile_blitter.sv
      - logic/wb_write_master.sv
      - logic/page_render_top.sv
  - target: simulation
    files:
      - verif/fb_memory_model.sv
      - verif/page_render_assert.sv
      - verif/page_render_tb.sv

//--- page_render_top.f
+incdir+include
logic/page_render_pkg.sv
logic/glyph_rom.sv
logic/page_sequencer.sv
logic/tile_blitter.sv
logic/wb_write_master.sv
logic/page_render_top.sv
verif/fb_memory_model.sv
verif/page_render_assert.sv
verif/page_render_tb.sv

//--- glyphs.hex
// Glyph bytes, two per row (left byte first, bit 0 leftmost); each line is 8 rows of one glyph.
FF FF 01 80 01 80 01 80 01 80 01 80 01 80 01 80
01 80 01 80 01 80 01 80 01 80 01 80 01 80 FF FF
01 00 02 00 04 00 08 00 10 00 20 00 40 00 80 00
00 01 00 02 00 04 00 08 00 10 00 20 00 40 00 80
AA AA 55 55 AA AA 55 55 AA AA 55 55 AA AA 55 55
AA AA 55 55 AA AA 55 55 AA AA 55 55 AA AA 55 55
01 00 03 00 07 00 0F 00 1F 00 3F 00 7F 00 FF 00
FF 01 FF 03 FF 07 FF 0F FF 1F FF 3F FF 7F FF FF
